// ==== verif/rs_patterns.txt ====
# fl de fu rob dst s1 r1 im op2 r2 | cdb0 v tag | cdb1 v tag | full iv0 rob0 iv1 rob1 (hex)
# Expected columns are the outputs during the cycle, before the line's inputs are clocked
# ready at dispatch, one per class
0 1 0 01 10 01 1 0 02 1   0 00   0 00   0 0 00 0 00
0 1 1 02 11 03 1 0 04 1   0 00   0 00   0 1 01 0 00
# CDB wakeup, then capture in the dispatch cycle on lane 1
0 1 0 03 12 20 0 0 21 1   0 00   0 00   0 0 00 1 02
0 0 0 00 00 00 0 0 00 0   1 20   0 00   0 0 00 0 00
0 1 1 04 13 05 1 0 22 0   0 00   1 22   0 1 03 0 00
# immediate operand waits on src1 only
0 1 0 05 14 23 0 1 3f 0   0 00   0 00   0 0 00 1 04
0 0 0 00 00 00 0 0 00 0   0 00   0 00   0 0 00 0 00
0 0 0 00 00 00 0 0 00 0   0 00   1 23   0 0 00 0 00
# shared wakeup, lowest slot first, classes in parallel
0 1 0 06 15 30 0 0 31 1   0 00   0 00   0 1 05 0 00
0 1 0 07 16 30 0 0 31 1   0 00   0 00   0 0 00 0 00
0 1 1 08 17 30 0 0 31 1   0 00   0 00   0 0 00 0 00
0 1 0 09 18 30 0 0 31 1   0 00   0 00   0 0 00 0 00
0 1 1 0a 19 30 0 0 31 1   1 30   0 00   0 0 00 0 00
0 0 0 00 00 00 0 0 00 0   0 00   0 00   0 1 07 1 08
0 0 0 00 00 00 0 0 00 0   0 00   0 00   0 1 06 1 0a
# fill all eight slots, one wakes and frees a slot
0 1 0 0b 1a 34 0 0 35 1   0 00   0 00   0 1 09 0 00
0 1 1 0c 1b 33 0 0 35 1   0 00   0 00   0 0 00 0 00
0 1 0 0d 1c 33 0 0 35 1   0 00   0 00   0 0 00 0 00
0 1 1 0e 1d 33 0 0 35 1   0 00   0 00   0 0 00 0 00
0 1 0 0f 1e 33 0 0 35 1   0 00   0 00   0 0 00 0 00
0 1 1 10 1f 33 0 0 35 1   0 00   0 00   0 0 00 0 00
0 1 0 11 20 33 0 0 35 1   0 00   0 00   0 0 00 0 00
0 1 1 12 21 33 0 0 35 1   0 00   0 00   0 0 00 0 00
0 0 0 00 00 00 0 0 00 0   1 34   0 00   1 0 00 0 00
0 0 0 00 00 00 0 0 00 0   0 00   0 00   1 1 0b 0 00
# flush beats a dispatch, later wakeup finds nothing
1 1 1 13 22 06 1 0 07 1   0 00   0 00   0 0 00 0 00
0 0 0 00 00 00 0 0 00 0   1 33   0 00   0 0 00 0 00
0 0 0 00 00 00 0 0 00 0   0 00   0 00   0 0 00 0 00
0 1 1 14 23 08 1 1 15 0   0 00   0 00   0 0 00 0 00
0 0 0 00 00 00 0 0 00 0   0 00   0 00   0 0 00 1 14
0 0 0 00 00 00 0 0 00 0   0 00   0 00   0 0 00 0 00

// ==== rs_top.f ====
hdl/rs_cfg_pkg.sv
hdl/rs_types_pkg.sv
hdl/rs_alloc.sv
hdl/rs_single_entry.sv
hdl/rs_issue_select.sv
hdl/rs_top.sv
verif/rs_top_chk.sv
verif/tb_rs_top.sv

// ==== Makefile ====
# Verilator flow for the reservation station

VERILATOR ?= verilator
FLIST     ?= rs_top.f
TB_TOP    ?= tb_rs_top
BUILD_DIR ?= obj_dir
LINTFLAGS ?= --lint-only --timing --assert
VFLAGS    ?= --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TB_TOP)

# Pass only when the run prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/tb_rs_top.sv ====
// ================================================
// Pattern-driven testbench for the station
// Run from the project root, reads verif/rs_patterns.txt
// Expected outputs of a line are seen before its inputs
// are clocked in
// ================================================
`timescale 1ns/1ns

module tb_rs_top
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;
();

    localparam int RESET_CYCLES  = 8;
    localparam int MARGIN_CYCLES = 16;
    localparam int FIELDS        = 19;

    // One pattern line, stimulus then expected outputs
    typedef struct packed {
        logic                         flush;
        logic                         disp_en;
        disp_packet_t                 pkt;
        cdb_t [CDB_WIDTH-1:0]         cdb;
        logic                         full;
        logic [FU_NUM-1:0]            iv;
        logic [FU_NUM-1:0][ROB_W-1:0] rob;
    } pattern_t;

    logic                    clock = 1'b0;
    logic                    reset;
    logic                    flush;
    logic                    disp_en;
    disp_packet_t            disp_pkt;
    cdb_t [CDB_WIDTH-1:0]    cdb;
    logic                    full;
    logic [FU_NUM-1:0]       issue_valid;
    issue_pkt_t [FU_NUM-1:0] issue_pkt;

    pattern_t     rows[$];
    // Dispatched instructions, looked up by ROB index
    disp_packet_t sent_by_rob [2**ROB_W];
    int           cycle_count = 0;
    int           cycle_limit = 0;

    rs_top UUT (
        .clock         (clock),
        .reset         (reset),
        .flush_i       (flush),
        .disp_en_i     (disp_en),
        .disp_pkt_i    (disp_pkt),
        .cdb_i         (cdb),
        .full_o        (full),
        .issue_valid_o (issue_valid),
        .issue_pkt_o   (issue_pkt)
    );

    // Port checks, grant vector taken from inside the top
    bind rs_top rs_top_chk u_chk (
        .clock            (clock),
        .reset            (reset),
        .flush_i          (flush_i),
        .disp_en_i        (disp_en_i),
        .disp_pkt_valid_i (disp_pkt_i.valid),
        .full_i           (full_o),
        .grant_i          (grant),
        .issue_valid_i    (issue_valid_o)
    );

    // 8 ns period
    always #4 clock = ~clock;

    // Run limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            abort_run($sformatf("timeout: run did not end within %0d cycles", cycle_limit));
        end
    end

    // ================================================
    // Helpers
    // ================================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("error: time %0t, %s expected %0h, actual %0h",
                                $time, name, expected, actual));
        end
    endtask

    // What a unit should receive for a dispatched instruction
    function automatic issue_pkt_t issue_view(input disp_packet_t pkt);
        issue_pkt_t view;
        view.rob_idx  = pkt.rob_idx;
        view.dest_tag = pkt.dest_tag;
        view.src1_tag = pkt.src1_tag;
        view.use_imm  = pkt.use_imm;
        view.op2      = pkt.op2;
        return view;
    endfunction

    task automatic load_patterns();
        int          fd;
        int          n_read;
        string       line;
        logic [31:0] fld [FIELDS];
        pattern_t    row;
        fd = $fopen("verif/rs_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verif/rs_patterns.txt");
        end
        while ($fgets(line, fd) != 0) begin
            // Comment and blank lines match nothing
            n_read = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                             fld[7], fld[8], fld[9], fld[10], fld[11], fld[12],
                             fld[13], fld[14], fld[15], fld[16], fld[17], fld[18]);
            if (n_read == FIELDS) begin
                row                  = '0;
                row.flush            = fld[0][0];
                row.disp_en          = fld[1][0];
                row.pkt.valid        = fld[1][0];
                row.pkt.fu_type      = fld[2][FU_W-1:0];
                row.pkt.rob_idx      = fld[3][ROB_W-1:0];
                row.pkt.dest_tag     = fld[4][TAG_W-1:0];
                row.pkt.src1_tag     = fld[5][TAG_W-1:0];
                row.pkt.src1_ready   = fld[6][0];
                row.pkt.use_imm      = fld[7][0];
                row.pkt.op2.src2_tag = fld[8][TAG_W-1:0];
                row.pkt.src2_ready   = fld[9][0];
                row.cdb[0].valid     = fld[10][0];
                row.cdb[0].tag       = fld[11][TAG_W-1:0];
                row.cdb[1].valid     = fld[12][0];
                row.cdb[1].tag       = fld[13][TAG_W-1:0];
                row.full             = fld[14][0];
                row.iv[0]            = fld[15][0];
                row.rob[0]           = fld[16][ROB_W-1:0];
                row.iv[1]            = fld[17][0];
                row.rob[1]           = fld[18][ROB_W-1:0];
                rows.push_back(row);
            end else if (n_read > 0) begin
                abort_run($sformatf("malformed pattern line: %s", line));
            end
        end
        $fclose(fd);
        if (rows.size() == 0) begin
            abort_run("pattern file holds no stimulus lines");
        end
    endtask

    task automatic drive_row(input pattern_t row);
        flush    <= row.flush;
        disp_en  <= row.disp_en;
        disp_pkt <= row.pkt;
        cdb      <= row.cdb;
        // Remember it for the later issue check
        if (row.disp_en) begin
            sent_by_rob[row.pkt.rob_idx] = row.pkt;
        end
    endtask

    task automatic check_row(input pattern_t row);
        issue_pkt_t want;
        compare("full_o", 32'(row.full), 32'(full));
        for (int c = 0; c < FU_NUM; c++) begin
            // Idle class shows a zero packet
            if (row.iv[c]) begin
                want = issue_view(sent_by_rob[row.rob[c]]);
            end else begin
                want = '0;
            end
            compare($sformatf("issue_valid_o[%0d]", c), 32'(row.iv[c]), 32'(issue_valid[c]));
            compare($sformatf("issue_pkt_o[%0d]", c), 32'(want), 32'(issue_pkt[c]));
        end
    endtask

    // ================================================
    // Main sequence
    // ================================================
    initial begin
        reset    = 1'b1;
        flush    = 1'b0;
        disp_en  = 1'b0;
        disp_pkt = '0;
        cdb      = '0;
        load_patterns();
        cycle_limit = RESET_CYCLES + rows.size() + MARGIN_CYCLES;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        // Drive on the rising edge, sample mid-cycle
        foreach (rows[n]) begin
            drive_row(rows[n]);
            @(negedge clock);
            check_row(rows[n]);
            @(posedge clock);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== verif/rs_top_chk.sv ====
// ================================================
// Bound checks on the reservation station ports
// Grant vector comes from inside rs_top
// ================================================
`timescale 1ns/1ns

module rs_top_chk
    import rs_cfg_pkg::*;
(
    input logic                  clock,
    input logic                  reset,
    input logic                  flush_i,
    input logic                  disp_en_i,
    input logic                  disp_pkt_valid_i,
    input logic                  full_i,
    input logic [RS_ENTRIES-1:0] grant_i,
    input logic [FU_NUM-1:0]     issue_valid_i
);

    // Dispatch only into a free slot
    a_no_disp_full: assert property (@(posedge clock) disable iff (reset)
        (disp_en_i && disp_pkt_valid_i) |-> !full_i)
        else $error("dispatch while the station is full");

    // Issued slot is released at once, so it never issues twice in a row
    a_slot_release: assert property (@(posedge clock) disable iff (reset)
        (grant_i & $past(grant_i)) == '0)
        else $error("slot issued in two consecutive cycles");

    // Nothing issues straight after reset
    a_quiet_reset: assert property (@(posedge clock)
        $past(reset) |-> (issue_valid_i == '0))
        else $error("issue right after reset");

    // Or straight after a flush
    a_quiet_flush: assert property (@(posedge clock) disable iff (reset)
        $past(flush_i) |-> (issue_valid_i == '0))
        else $error("issue right after flush");

endmodule

// ==== hdl/rs_top.sv ====
// ================================================
// Reservation station top level
// Allocator, slot array and per-class selector
// No back-pressure from the functional units
// ================================================
`timescale 1ns/1ns

module rs_top
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        flush_i,
    input  logic                        disp_en_i,
    input  disp_packet_t                disp_pkt_i,
    input  cdb_t [CDB_WIDTH-1:0]        cdb_i,
    output logic                        full_o,
    output logic [FU_NUM-1:0]           issue_valid_o,
    output issue_pkt_t [FU_NUM-1:0]     issue_pkt_o
);

    // Per-slot status and data
    logic [RS_ENTRIES-1:0]           entry_empty;
    logic [RS_ENTRIES-1:0]           entry_write;
    logic [RS_ENTRIES-1:0]           entry_ready;
    logic [RS_ENTRIES-1:0][FU_W-1:0] entry_fu;
    issue_pkt_t [RS_ENTRIES-1:0]     entry_pkt;
    logic [RS_ENTRIES-1:0]           grant;

    // ================================================
    // Dispatch allocation
    // ================================================
    rs_alloc u_alloc (
        .disp_en_i        (disp_en_i),
        .disp_pkt_valid_i (disp_pkt_i.valid),
        .entry_empty_i    (entry_empty),
        .entry_write_o    (entry_write),
        .full_o           (full_o)
    );

    // Slot array
    for (genvar i = 0; i < RS_ENTRIES; i++) begin : g_entry
        rs_single_entry u_entry (
            .clock       (clock),
            .reset       (reset),
            .flush_i     (flush_i),
            .write_i     (entry_write[i]),
            .disp_pkt_i  (disp_pkt_i),
            .cdb_i       (cdb_i),
            .issue_i     (grant[i]),
            .empty_o     (entry_empty[i]),
            .ready_o     (entry_ready[i]),
            .fu_type_o   (entry_fu[i]),
            .issue_pkt_o (entry_pkt[i])
        );
    end

    // Issue selection
    rs_issue_select u_select (
        .entry_ready_i (entry_ready),
        .entry_fu_i    (entry_fu),
        .entry_pkt_i   (entry_pkt),
        .grant_o       (grant),
        .issue_valid_o (issue_valid_o),
        .issue_pkt_o   (issue_pkt_o)
    );

endmodule

// ==== hdl/rs_issue_select.sv ====
// ================================================
// Issue selection per functional-unit class
// Lowest ready slot of a class wins, no age order
// Units always accept, so a grant is an issue
// ================================================
`timescale 1ns/1ns

module rs_issue_select
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;
(
    input  logic [RS_ENTRIES-1:0]            entry_ready_i,
    input  logic [RS_ENTRIES-1:0][FU_W-1:0]  entry_fu_i,
    input  issue_pkt_t [RS_ENTRIES-1:0]      entry_pkt_i,
    output logic [RS_ENTRIES-1:0]            grant_o,
    output logic [FU_NUM-1:0]                issue_valid_o,
    output issue_pkt_t [FU_NUM-1:0]          issue_pkt_o
);

    // Per-class ready vectors
    logic [FU_NUM-1:0][RS_ENTRIES-1:0] class_ready;

    // Split ready bits by class
    always_comb begin
        for (int c = 0; c < FU_NUM; c++) begin
            for (int i = 0; i < RS_ENTRIES; i++) begin
                class_ready[c][i] = entry_ready_i[i] && (entry_fu_i[i] == FU_W'(c));
            end
        end
    end

    // ================================================
    // Priority pick
    // ================================================
    always_comb begin
        grant_o       = '0;
        issue_valid_o = '0;
        issue_pkt_o   = '0;
        for (int c = 0; c < FU_NUM; c++) begin
            // Search from slot 0, first ready slot of the class
            for (int i = 0; i < RS_ENTRIES; i++) begin
                if (class_ready[c][i] && !issue_valid_o[c]) begin
                    issue_valid_o[c] = 1'b1;
                    grant_o[i]       = 1'b1;
                    issue_pkt_o[c]   = entry_pkt_i[i];
                end
            end
        end
    end

    // Each slot belongs to one class, so grants never collide

endmodule

// ==== hdl/rs_single_entry.sv ====
// ================================================
// One reservation station slot
// Write strobe must only hit an empty slot
// Wakeup also applies to the packet being written
// ================================================
`timescale 1ns/1ns

module rs_single_entry
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        flush_i,
    input  logic                        write_i,
    input  disp_packet_t                disp_pkt_i,
    input  cdb_t [CDB_WIDTH-1:0]        cdb_i,
    input  logic                        issue_i,
    output logic                        empty_o,
    output logic                        ready_o,
    output logic [FU_W-1:0]             fu_type_o,
    output issue_pkt_t                  issue_pkt_o
);

    // Slot occupied flag
    logic         busy_q;
    // Held instruction and its next value
    disp_packet_t entry_q;
    disp_packet_t entry_d;

    // Any valid CDB lane carrying this tag
    function automatic logic cdb_hit(input logic [TAG_W-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            hit = hit | (cdb_i[k].valid && (cdb_i[k].tag == tag));
        end
        return hit;
    endfunction

    // ================================================
    // Wakeup and capture
    // ================================================
    always_comb begin
        entry_d = entry_q;
        // Resident instruction accumulates ready bits
        entry_d.src1_ready = entry_q.src1_ready | cdb_hit(entry_q.src1_tag);
        entry_d.src2_ready = entry_q.src2_ready
                           | (!entry_q.use_imm && cdb_hit(entry_q.op2.src2_tag));
        if (write_i) begin
            entry_d = disp_pkt_i;
            // Same-cycle broadcast is caught on the way in
            entry_d.src1_ready = disp_pkt_i.src1_ready | cdb_hit(disp_pkt_i.src1_tag);
            // Immediate counts as ready, never matched
            entry_d.src2_ready = disp_pkt_i.use_imm | disp_pkt_i.src2_ready
                               | cdb_hit(disp_pkt_i.op2.src2_tag);
        end
    end

    // Payload
    always_ff @(posedge clock) begin
        entry_q <= entry_d;
    end

    // Occupancy, flush wins over dispatch
    always_ff @(posedge clock) begin
        if (reset || flush_i) begin
            busy_q <= 1'b0;
        end else if (write_i) begin
            busy_q <= 1'b1;
        end else if (issue_i) begin
            busy_q <= 1'b0;
        end
    end

    // ================================================
    // Outputs
    // ================================================
    assign empty_o   = !busy_q;
    assign ready_o   = busy_q && entry_q.src1_ready && entry_q.src2_ready;
    assign fu_type_o = entry_q.fu_type;

    // Unit-facing view of the held instruction
    assign issue_pkt_o.rob_idx  = entry_q.rob_idx;
    assign issue_pkt_o.dest_tag = entry_q.dest_tag;
    assign issue_pkt_o.src1_tag = entry_q.src1_tag;
    assign issue_pkt_o.use_imm  = entry_q.use_imm;
    assign issue_pkt_o.op2      = entry_q.op2;

endmodule

// ==== hdl/rs_alloc.sv ====
// ================================================
// Slot allocator for dispatch
// Lowest empty slot wins, one write per cycle
// Dispatch while full is silently dropped
// ================================================
`timescale 1ns/1ns

module rs_alloc
    import rs_cfg_pkg::*;
(
    input  logic                  disp_en_i,
    input  logic                  disp_pkt_valid_i,
    input  logic [RS_ENTRIES-1:0] entry_empty_i,
    output logic [RS_ENTRIES-1:0] entry_write_o,
    output logic                  full_o
);

    // Lowest empty slot as a one-hot mask
    logic [RS_ENTRIES-1:0] first_empty;

    // Combined dispatch request
    logic                  disp_req;

    assign disp_req = disp_en_i && disp_pkt_valid_i;

    // Priority search from slot 0 upwards
    always_comb begin
        first_empty = '0;
        for (int i = 0; i < RS_ENTRIES; i++) begin
            // Stop at the first hit
            if (entry_empty_i[i] && (first_empty == '0)) begin
                first_empty[i] = 1'b1;
            end
        end
    end

    // Steer the strobe, nothing when no slot is free
    assign entry_write_o = disp_req ? first_empty : '0;

    // Full when no slot reports empty
    assign full_o = ~|entry_empty_i;

endmodule

// ==== hdl/rs_types_pkg.sv ====
// ================================================
// Packet and broadcast formats of the station
// Second operand is a tag or an immediate
// Only tags are carried, never register values
// ================================================

package rs_types_pkg;

    import rs_cfg_pkg::*;

    // Second operand word, decoded by use_imm
    typedef union packed {
        logic [TAG_W-1:0] src2_tag;
        logic [IMM_W-1:0] imm;
    } operand2_u;

    // ================================================
    // Dispatch side
    // ================================================

    // Renamed instruction as it leaves dispatch
    typedef struct packed {
        logic             valid;
        logic [FU_W-1:0]  fu_type;
        logic [ROB_W-1:0] rob_idx;
        logic [TAG_W-1:0] dest_tag;
        logic [TAG_W-1:0] src1_tag;
        logic             src1_ready;
        logic             use_imm;
        operand2_u        op2;
        logic             src2_ready;
    } disp_packet_t;

    // One CDB lane
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } cdb_t;

    // ================================================
    // Issue side
    // ================================================

    // Fields a functional unit needs
    typedef struct packed {
        logic [ROB_W-1:0] rob_idx;
        logic [TAG_W-1:0] dest_tag;
        logic [TAG_W-1:0] src1_tag;
        logic             use_imm;
        operand2_u        op2;
    } issue_pkt_t;

endpackage

// ==== hdl/rs_cfg_pkg.sv ====
// ================================================
// Sizes of the reservation station
// Tag width follows the physical register count
// Immediate field must stay as wide as a tag
// ================================================

package rs_cfg_pkg;

    // Station slots
    localparam int RS_ENTRIES = 8;

    // Physical register file and tag width
    localparam int PHYS_REGS = 64;
    localparam int TAG_W     = $clog2(PHYS_REGS);

    // Result broadcasts per cycle
    localparam int CDB_WIDTH = 2;

    // Functional-unit classes, 0 is ALU and 1 is memory
    localparam int FU_NUM = 2;
    localparam int FU_W   = $clog2(FU_NUM);

    // ROB index and immediate widths
    localparam int ROB_W = 5;
    localparam int IMM_W = TAG_W;

endpackage
